// ==== logic/bus_pkg.sv ====
// register bus types shared by the slave, the top level and the testbench.
package bus_pkg;

  // plain bus vectors.
  typedef logic [15:0] wb_addr_t;
  typedef logic [15:0] wb_data_t;

  // signals driven by the bus master.
  // adr, we and dat are held until ack or err is seen.
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  // signals driven by the slave.
  // ack and err are single cycle pulses, dat is valid with ack.
  typedef struct packed {
    logic     ack;
    logic     err;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

// ==== logic/monitor_pkg.sv ====
// ADC sample, threshold and channel status types plus the register map.
package monitor_pkg;

  typedef logic [11:0] adc_result_t;  // one conversion result.
  typedef logic [4:0]  adc_channel_t; // ADC channel number.

  // sample stream from the ADC controller, no back-pressure.
  typedef struct packed {
    logic         strb;
    adc_channel_t channel;
    adc_result_t  result;
  } adc_sample_t;

  // limits of one monitored channel.
  typedef struct packed {
    adc_result_t soft_lo;
    adc_result_t soft_hi;
    adc_result_t hard_lo;
    adc_result_t hard_hi;
  } thresh_set_t;

  // per channel compare result.
  typedef struct packed {
    logic valid;     // high in the cycle the flags are updated.
    logic in_range;
    logic soft_viol;
    logic hard_viol;
  } chan_status_t;

  // channel c, field f lives at THRESH_BASE + 4c + f
  localparam logic [15:0] THRESH_BASE     = 16'h0000;
  localparam logic [15:0] STATUS_IN_RANGE = 16'h0100;
  localparam logic [15:0] STATUS_SOFT     = 16'h0101; // write one to clear.
  localparam logic [15:0] STATUS_HARD     = 16'h0102; // write one to clear.
  localparam logic [15:0] IRQ_MASK        = 16'h0103;

  // reset values of the windows.
  localparam adc_result_t RESULT_MIN = 12'h000;
  localparam adc_result_t RESULT_MAX = 12'hFFF;

endpackage

// ==== logic/sample_router.sv ====
module sample_router #(
  parameter int NUM_CHANNELS = 8
) (
  input  logic                     wb_clk_i,
  input  logic                     rst_i,
  input  monitor_pkg::adc_sample_t sample_i,
  output logic [NUM_CHANNELS-1:0]  chan_strb_o,
  output monitor_pkg::adc_result_t result_o
);

  logic [NUM_CHANNELS-1:0] strb_dec;

  // channel numbers outside the monitored set decode to no strobe.
  always_comb begin
    strb_dec = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      strb_dec[c] = sample_i.strb && (sample_i.channel == monitor_pkg::adc_channel_t'(c));
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      chan_strb_o <= '0;
    end else begin
      chan_strb_o <= strb_dec;
    end
  end

  // shared result, only meaningful alongside a strobe.
  always_ff @(posedge wb_clk_i) begin
    if (sample_i.strb) begin
      result_o <= sample_i.result;
    end
  end

  // at most one channel sees each sample.
  a_strb_onehot: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    $onehot0(chan_strb_o));

endmodule

// ==== logic/level_channel.sv ====
module level_channel (
  input  logic                      wb_clk_i,
  input  logic                      rst_i,
  input  logic                      strb_i,
  input  monitor_pkg::adc_result_t  result_i,
  input  monitor_pkg::thresh_set_t  thresh_i,
  output monitor_pkg::chan_status_t status_o
);

  logic valid_q;
  logic in_range_q;
  logic soft_viol_q;
  logic hard_viol_q;

  logic in_soft;
  logic out_hard;

  // window compares on the routed result.
  assign in_soft = (result_i >= thresh_i.soft_lo) && (result_i <= thresh_i.soft_hi);

  // below hard_lo or above hard_hi
  assign out_hard = (result_i < thresh_i.hard_lo) || (result_i > thresh_i.hard_hi);

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= strb_i; // single cycle per sample.
    end
  end

  // flags hold their last value between samples.
  always_ff @(posedge wb_clk_i) begin
    if (strb_i) begin
      in_range_q  <= in_soft;
      soft_viol_q <= ~in_soft;
      hard_viol_q <= out_hard;
    end
  end

  assign status_o = '{
    valid:     valid_q,
    in_range:  in_range_q,
    soft_viol: soft_viol_q,
    hard_viol: hard_viol_q
  };

endmodule

// ==== logic/violation_collector.sv ====
module violation_collector #(
  parameter int NUM_CHANNELS = 8
) (
  input  logic                                        wb_clk_i,
  input  logic                                        rst_i,
  input  monitor_pkg::chan_status_t [NUM_CHANNELS-1:0] status_i,
  input  logic [15:0]                                 soft_clr_i,
  input  logic [15:0]                                 hard_clr_i,
  input  logic [15:0]                                 irq_mask_i,
  output logic [15:0]                                 in_range_o,
  output logic [15:0]                                 soft_sticky_o,
  output logic [15:0]                                 hard_sticky_o,
  output logic                                        irq_o,
  output logic                                        hard_viol_o
);

  // only the monitored channels start out in range.
  localparam logic [15:0] CHAN_MASK = 16'((32'd1 << NUM_CHANNELS) - 32'd1);

  logic [15:0] in_range_d;
  logic [15:0] soft_d;
  logic [15:0] hard_d;
  logic [15:0] hard_set;

  // clear first and then set, so a new violation wins over a clear.
  always_comb begin
    in_range_d = in_range_o;
    soft_d     = soft_sticky_o & ~soft_clr_i;
    hard_set   = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (status_i[c].valid) begin
        in_range_d[c] = status_i[c].in_range;
        soft_d[c]     = soft_d[c] | status_i[c].soft_viol;
        hard_set[c]   = status_i[c].hard_viol;
      end
    end
    hard_d = (hard_sticky_o & ~hard_clr_i) | hard_set;
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      in_range_o    <= CHAN_MASK;
      soft_sticky_o <= '0;
      hard_sticky_o <= '0;
      irq_o         <= 1'b0;
      hard_viol_o   <= 1'b0;
    end else begin
      in_range_o    <= in_range_d;
      soft_sticky_o <= soft_d;
      hard_sticky_o <= hard_d;
      irq_o         <= |(soft_d & irq_mask_i); // moves with the sticky bits.
      hard_viol_o   <= |hard_d;
    end
  end

  // status registers are 16 bits wide.
  a_num_channels: assert property (@(posedge wb_clk_i)
    (NUM_CHANNELS >= 1) && (NUM_CHANNELS <= 16));

endmodule

// ==== logic/wb_monitor_regs.sv ====
module wb_monitor_regs #(
  parameter int NUM_CHANNELS = 8
) (
  input  logic                                       wb_clk_i,
  input  logic                                       rst_i,
  input  bus_pkg::wb_req_t                           wb_req_i,
  output bus_pkg::wb_rsp_t                           wb_rsp_o,
  output monitor_pkg::thresh_set_t [NUM_CHANNELS-1:0] thresh_o,
  output logic [15:0]                                soft_clr_o,
  output logic [15:0]                                hard_clr_o,
  output logic [15:0]                                irq_mask_o,
  input  logic [15:0]                                in_range_i,
  input  logic [15:0]                                soft_sticky_i,
  input  logic [15:0]                                hard_sticky_i
);

  localparam logic [15:0] THRESH_SPAN = 16'(4 * NUM_CHANNELS);

  logic              ack_q;
  logic              err_q;
  bus_pkg::wb_data_t rd_q;

  logic              req;
  logic              wr;
  logic [15:0]       thr_off;
  logic              thr_hit;
  logic [3:0]        thr_chan;
  logic [1:0]        thr_field;
  monitor_pkg::adc_result_t thr_word;
  logic              mapped;
  bus_pkg::wb_data_t rd_data;

  // a request is new until it has been answered.
  assign req = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
  assign wr  = req && wb_req_i.we;

  // addresses below the base wrap and miss.
  assign thr_off   = wb_req_i.adr - monitor_pkg::THRESH_BASE;
  assign thr_hit   = thr_off < THRESH_SPAN;
  assign thr_chan  = thr_off[5:2];
  assign thr_field = thr_off[1:0];

  always_comb begin
    thr_word = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (thr_chan == 4'(c)) begin
        case (thr_field)
          2'd0:    thr_word = thresh_o[c].soft_lo;
          2'd1:    thr_word = thresh_o[c].soft_hi;
          2'd2:    thr_word = thresh_o[c].hard_lo;
          default: thr_word = thresh_o[c].hard_hi;
        endcase
      end
    end
  end

  // address decode and read mux.
  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    if (thr_hit) begin
      rd_data = {4'b0, thr_word};
    end else begin
      case (wb_req_i.adr)
        monitor_pkg::STATUS_IN_RANGE: rd_data = in_range_i;
        monitor_pkg::STATUS_SOFT:     rd_data = soft_sticky_i;
        monitor_pkg::STATUS_HARD:     rd_data = hard_sticky_i;
        monitor_pkg::IRQ_MASK:        rd_data = irq_mask_o;
        default:                      mapped  = 1'b0;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
      soft_clr_o <= '0;
      hard_clr_o <= '0;
      irq_mask_o <= '0;
    end else begin
      ack_q      <= req && mapped;
      err_q      <= req && !mapped;
      soft_clr_o <= '0; // clear masks last one cycle.
      hard_clr_o <= '0;
      if (wr && wb_req_i.adr == monitor_pkg::STATUS_SOFT) begin
        soft_clr_o <= wb_req_i.dat;
      end
      if (wr && wb_req_i.adr == monitor_pkg::STATUS_HARD) begin
        hard_clr_o <= wb_req_i.dat;
      end
      if (wr && wb_req_i.adr == monitor_pkg::IRQ_MASK) begin
        irq_mask_o <= wb_req_i.dat;
      end
    end
  end

  // windows open fully out of reset.
  always_ff @(posedge wb_clk_i) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (rst_i) begin
        thresh_o[c].soft_lo <= monitor_pkg::RESULT_MIN;
        thresh_o[c].soft_hi <= monitor_pkg::RESULT_MAX;
        thresh_o[c].hard_lo <= monitor_pkg::RESULT_MIN;
        thresh_o[c].hard_hi <= monitor_pkg::RESULT_MAX;
      end else if (wr && thr_hit && thr_chan == 4'(c)) begin
        case (thr_field)
          2'd0:    thresh_o[c].soft_lo <= wb_req_i.dat[11:0];
          2'd1:    thresh_o[c].soft_hi <= wb_req_i.dat[11:0];
          2'd2:    thresh_o[c].hard_lo <= wb_req_i.dat[11:0];
          default: thresh_o[c].hard_hi <= wb_req_i.dat[11:0];
        endcase
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rd_q <= rd_data;
    end
  end

  assign wb_rsp_o = '{ack: ack_q, err: err_q, dat: rd_q};

  // every answer belongs to a request seen on the previous edge.
  a_rsp_req: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (ack_q || err_q) |-> $past(wb_req_i.cyc && wb_req_i.stb));

  a_rsp_excl: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(ack_q && err_q));

endmodule

// ==== logic/health_monitor_top.sv ====
module health_monitor_top #(
  parameter int NUM_CHANNELS = 8
) (
  input  logic                     wb_clk_i,
  input  logic                     rst_i,
  input  bus_pkg::wb_req_t         wb_req_i,
  output bus_pkg::wb_rsp_t         wb_rsp_o,
  input  monitor_pkg::adc_sample_t adc_sample_i,
  output logic                     irq_o,
  output logic                     hard_viol_o
);

  logic [NUM_CHANNELS-1:0]                    chan_strb;
  monitor_pkg::adc_result_t                   chan_result;
  monitor_pkg::thresh_set_t [NUM_CHANNELS-1:0] chan_thresh;
  monitor_pkg::chan_status_t [NUM_CHANNELS-1:0] chan_status;

  logic [15:0] soft_clr;
  logic [15:0] hard_clr;
  logic [15:0] irq_mask;
  logic [15:0] in_range;
  logic [15:0] soft_sticky;
  logic [15:0] hard_sticky;

  sample_router #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_sample_router (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i),
    .sample_i(adc_sample_i),
    .chan_strb_o(chan_strb), .result_o(chan_result)
  );

  // one comparator per monitored channel.
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    level_channel u_level_channel (
      .wb_clk_i(wb_clk_i), .rst_i(rst_i),
      .strb_i(chan_strb[c]), .result_i(chan_result),
      .thresh_i(chan_thresh[c]), .status_o(chan_status[c])
    );
  end

  violation_collector #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_violation_collector (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i),
    .status_i(chan_status),
    .soft_clr_i(soft_clr), .hard_clr_i(hard_clr), .irq_mask_i(irq_mask),
    .in_range_o(in_range), .soft_sticky_o(soft_sticky), .hard_sticky_o(hard_sticky),
    .irq_o(irq_o), .hard_viol_o(hard_viol_o)
  );

  wb_monitor_regs #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_wb_monitor_regs (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i),
    .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
    .thresh_o(chan_thresh),
    .soft_clr_o(soft_clr), .hard_clr_o(hard_clr), .irq_mask_o(irq_mask),
    .in_range_i(in_range), .soft_sticky_i(soft_sticky), .hard_sticky_i(hard_sticky)
  );

endmodule

// ==== verif/tb_health_monitor.sv ====
module tb_health_monitor;

  localparam int NUM_CHANNELS = 8;
  localparam int SOFT_CH      = (NUM_CHANNELS > 2) ? 2 : 0;
  localparam int HARD_CH      = NUM_CHANNELS - 1;
  localparam int RAND_BURSTS  = 24;
  localparam int BURST_LEN    = 12;
  localparam int BUS_TIMEOUT  = 16;

  // upper bounds on bus accesses and samples over all tests.
  localparam int BUS_OPS  = 8 * NUM_CHANNELS + 64 + 16 * RAND_BURSTS;
  localparam int SAMPLES  = 2 * NUM_CHANNELS + 40 + RAND_BURSTS * (BURST_LEN + 8);
  localparam int WATCHDOG_CYCLES = 2 * (4 * BUS_OPS + 2 * SAMPLES) + 200;

  localparam logic [15:0] ALL_CH = 16'((32'd1 << NUM_CHANNELS) - 32'd1);

  logic                     clk;
  logic                     rst;
  bus_pkg::wb_req_t         wb_req;
  bus_pkg::wb_rsp_t         wb_rsp;
  monitor_pkg::adc_sample_t adc_sample;
  logic                     irq;
  logic                     hard_viol;

  integer seed = 32'he230;
  int     errors;
  int     checks;
  int     test_errors;
  string  test_name;

  // reference model state.
  logic [11:0] m_thr [NUM_CHANNELS][4]; // soft_lo, soft_hi, hard_lo, hard_hi.
  logic [15:0] m_in_range;
  logic [15:0] m_soft;
  logic [15:0] m_hard;
  logic [15:0] m_mask;

  health_monitor_top #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_health_monitor_top (
    .wb_clk_i(clk), .rst_i(rst),
    .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
    .adc_sample_i(adc_sample),
    .irq_o(irq), .hard_viol_o(hard_viol)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string label, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error %s %s: expected 0x%0h, actual 0x%0h",
               test_name, label, expected, actual);
    end
  endtask

  function automatic logic [15:0] thr_addr(input int c, input int f);
    return 16'(int'(monitor_pkg::THRESH_BASE) + 4 * c + f);
  endfunction

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  task automatic model_reset();
    m_in_range = ALL_CH;
    m_soft     = '0;
    m_hard     = '0;
    m_mask     = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      m_thr[c][0] = 12'h000;
      m_thr[c][1] = 12'hFFF;
      m_thr[c][2] = 12'h000;
      m_thr[c][3] = 12'hFFF;
    end
  endtask

  task automatic model_write(input logic [15:0] adr, input logic [15:0] dat);
    int off;
    off = int'(adr) - int'(monitor_pkg::THRESH_BASE);
    if (off >= 0 && off < 4 * NUM_CHANNELS) begin
      m_thr[off / 4][off % 4] = dat[11:0]; // only the low 12 bits are kept.
    end else if (adr == monitor_pkg::STATUS_SOFT) begin
      m_soft = m_soft & ~dat;
    end else if (adr == monitor_pkg::STATUS_HARD) begin
      m_hard = m_hard & ~dat;
    end else if (adr == monitor_pkg::IRQ_MASK) begin
      m_mask = dat;
    end
  endtask

  task automatic model_sample(input int ch, input logic [11:0] res);
    logic in_soft;
    if (ch < NUM_CHANNELS) begin
      in_soft = (res >= m_thr[ch][0]) && (res <= m_thr[ch][1]);
      m_in_range[ch] = in_soft;
      if (!in_soft) begin
        m_soft[ch] = 1'b1;
      end
      if (res < m_thr[ch][2] || res > m_thr[ch][3]) begin
        m_hard[ch] = 1'b1;
      end
    end
  endtask

  // one access, held until ack or err.
  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [15:0] dat,
                            output logic [15:0] rdat, output logic got_ack,
                            output logic got_err);
    int waited;
    @(negedge clk);
    wb_req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    got_ack = 1'b0;
    got_err = 1'b0;
    rdat    = '0;
    waited  = 0;
    while (!got_ack && !got_err && waited < BUS_TIMEOUT) begin
      @(negedge clk);
      got_ack = wb_rsp.ack;
      got_err = wb_rsp.err;
      rdat    = wb_rsp.dat;
      waited++;
    end
    wb_req = '0; // stb stays low for at least one edge.
    if (!got_ack && !got_err) begin
      errors++;
      $display("bus access to address 0x%h got neither ack nor err", adr);
    end
  endtask

  task automatic bus_write(input logic [15:0] adr, input logic [15:0] dat);
    logic [15:0] rdat;
    logic        got_ack;
    logic        got_err;
    bus_access(1'b1, adr, dat, rdat, got_ack, got_err);
    if (got_err) begin
      errors++;
      $display("bus write to address 0x%h was answered with err", adr);
    end
    if (got_ack) begin
      model_write(adr, dat);
    end
  endtask

  task automatic bus_read(input logic [15:0] adr, output logic [15:0] rdat);
    logic got_ack;
    logic got_err;
    bus_access(1'b0, adr, 16'h0000, rdat, got_ack, got_err);
    if (got_err) begin
      errors++;
      $display("bus read from address 0x%h was answered with err", adr);
    end
  endtask

  task automatic read_expect(input string label, input logic [15:0] adr,
                             input logic [15:0] expected);
    logic [15:0] rdat;
    bus_read(adr, rdat);
    check_value(label, expected, rdat);
  endtask

  task automatic send_sample(input int ch, input logic [11:0] res);
    @(negedge clk);
    adc_sample = '{strb: 1'b1, channel: 5'(ch), result: res};
    model_sample(ch, res);
  endtask

  // drop the strobe and let the three stages drain.
  task automatic drain_samples();
    @(negedge clk);
    adc_sample.strb = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  task automatic settle();
    repeat (2) @(negedge clk);
  endtask

  task automatic compare_model(input string tag);
    read_expect({tag, " in_range"}, monitor_pkg::STATUS_IN_RANGE, m_in_range);
    read_expect({tag, " soft"}, monitor_pkg::STATUS_SOFT, m_soft);
    read_expect({tag, " hard"}, monitor_pkg::STATUS_HARD, m_hard);
    read_expect({tag, " mask"}, monitor_pkg::IRQ_MASK, m_mask);
    check_value({tag, " irq_o"}, 16'(|(m_soft & m_mask)), 16'(irq));
    check_value({tag, " hard_viol_o"}, 16'(|m_hard), 16'(hard_viol));
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", test_name, errors - test_errors);
  endtask

  task automatic test_reset_defaults();
    start_test("reset_defaults");
    check_value("irq_o", 16'h0000, 16'(irq));
    check_value("hard_viol_o", 16'h0000, 16'(hard_viol));
    read_expect("in_range", monitor_pkg::STATUS_IN_RANGE, ALL_CH);
    read_expect("soft", monitor_pkg::STATUS_SOFT, 16'h0000);
    read_expect("hard", monitor_pkg::STATUS_HARD, 16'h0000);
    read_expect("mask", monitor_pkg::IRQ_MASK, 16'h0000);
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int f = 0; f < 4; f++) begin
        read_expect($sformatf("thresh %0d.%0d", c, f), thr_addr(c, f),
                    (f % 2 == 0) ? 16'h0000 : 16'h0FFF); // lo fields at 0.
      end
    end
    end_test();
  endtask

  task automatic test_register_access();
    logic [15:0] rdat;
    logic        got_ack;
    logic        got_err;
    start_test("register_access");
    bus_write(thr_addr(0, 0), 16'hABCD);
    read_expect("soft_lo masked", thr_addr(0, 0), 16'h0BCD);
    bus_write(thr_addr(HARD_CH, 3), 16'hF123);
    read_expect("hard_hi masked", thr_addr(HARD_CH, 3), 16'h0123);
    bus_write(monitor_pkg::STATUS_IN_RANGE, 16'h0000); // read only, still acked.
    read_expect("in_range read only", monitor_pkg::STATUS_IN_RANGE, ALL_CH);
    bus_access(1'b1, 16'h0200, 16'h1234, rdat, got_ack, got_err);
    check_value("unmapped write err", 16'h0001, 16'(got_err));
    check_value("unmapped write ack", 16'h0000, 16'(got_ack));
    bus_access(1'b0, 16'h0104, 16'h0000, rdat, got_ack, got_err);
    check_value("unmapped read err", 16'h0001, 16'(got_err));
    check_value("unmapped read ack", 16'h0000, 16'(got_ack));
    bus_write(thr_addr(0, 0), 16'h0000);
    bus_write(thr_addr(HARD_CH, 3), 16'h0FFF);
    end_test();
  endtask

  task automatic test_soft_window();
    start_test("soft_window");
    bus_write(thr_addr(SOFT_CH, 0), 16'h0400);
    bus_write(thr_addr(SOFT_CH, 1), 16'h0800);
    send_sample(SOFT_CH, 12'h500);
    drain_samples();
    read_expect("inside in_range", monitor_pkg::STATUS_IN_RANGE, ALL_CH);
    send_sample(SOFT_CH, 12'h900);
    drain_samples();
    read_expect("outside in_range", monitor_pkg::STATUS_IN_RANGE,
                ALL_CH & ~(16'h1 << SOFT_CH));
    read_expect("outside soft", monitor_pkg::STATUS_SOFT, 16'h1 << SOFT_CH);
    check_value("irq without mask", 16'h0000, 16'(irq));
    bus_write(monitor_pkg::IRQ_MASK, ~(16'h1 << SOFT_CH));
    settle();
    check_value("irq other mask", 16'h0000, 16'(irq));
    bus_write(monitor_pkg::IRQ_MASK, 16'h1 << SOFT_CH);
    settle();
    check_value("irq with mask", 16'h0001, 16'(irq));
    bus_write(monitor_pkg::STATUS_SOFT, 16'h1 << SOFT_CH);
    settle();
    check_value("irq after clear", 16'h0000, 16'(irq));
    compare_model("cleared");
    end_test();
  endtask

  task automatic test_hard_window();
    start_test("hard_window");
    bus_write(thr_addr(HARD_CH, 2), 16'h0100);
    bus_write(thr_addr(HARD_CH, 3), 16'h0E00);
    send_sample(HARD_CH, 12'hF00);
    @(negedge clk);
    adc_sample.strb = 1'b0;
    check_value("hard_viol_o after 1 cycle", 16'h0000, 16'(hard_viol));
    @(negedge clk);
    check_value("hard_viol_o after 2 cycles", 16'h0000, 16'(hard_viol));
    @(negedge clk);
    check_value("hard_viol_o after 3 cycles", 16'h0001, 16'(hard_viol));
    repeat (5) @(negedge clk);
    check_value("hard_viol_o held", 16'h0001, 16'(hard_viol));
    bus_write(monitor_pkg::STATUS_HARD, ~(16'h1 << HARD_CH));
    settle();
    check_value("hard_viol_o other clear", 16'h0001, 16'(hard_viol));
    bus_write(monitor_pkg::STATUS_HARD, 16'h1 << HARD_CH);
    settle();
    check_value("hard_viol_o cleared", 16'h0000, 16'(hard_viol));
    send_sample(HARD_CH, 12'h050); // below hard_lo.
    drain_samples();
    check_value("hard_viol_o low side", 16'h0001, 16'(hard_viol));
    bus_write(monitor_pkg::STATUS_HARD, 16'hFFFF);
    settle();
    compare_model("hard cleared");
    end_test();
  endtask

  task automatic test_pipeline_filter();
    start_test("pipeline_filter");
    bus_write(monitor_pkg::STATUS_SOFT, 16'hFFFF);
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      bus_write(thr_addr(c, 1), 16'h07FF);
    end
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      send_sample(c, 12'(12'h800 + c)); // one per cycle.
    end
    drain_samples();
    read_expect("burst soft", monitor_pkg::STATUS_SOFT, ALL_CH);
    read_expect("burst in_range", monitor_pkg::STATUS_IN_RANGE, 16'h0000);
    compare_model("burst");
    bus_write(monitor_pkg::STATUS_SOFT, 16'hFFFF);
    settle();
    send_sample(NUM_CHANNELS, 12'hFFF);
    send_sample(31, 12'hFFF);
    drain_samples();
    read_expect("filtered soft", monitor_pkg::STATUS_SOFT, 16'h0000);
    read_expect("filtered hard", monitor_pkg::STATUS_HARD, 16'h0000);
    compare_model("filtered");
    end_test();
  endtask

  task automatic test_random_run();
    int          ch;
    logic [15:0] word;
    start_test("random_run");
    for (int b = 0; b < RAND_BURSTS; b++) begin
      ch = rand_below(NUM_CHANNELS);
      for (int f = 0; f < 4; f++) begin
        word = 16'($random(seed));
        // lo fields in the lower half and hi fields in the upper half.
        word = (f % 2 == 0) ? (word & ~16'h0800) : (word | 16'h0800);
        bus_write(thr_addr(ch, f), word);
      end
      bus_write(monitor_pkg::IRQ_MASK, 16'($random(seed)));
      for (int s = 0; s < BURST_LEN; s++) begin
        send_sample(rand_below(NUM_CHANNELS + 2), 12'($random(seed)));
      end
      drain_samples();
      compare_model($sformatf("burst %0d", b));
      bus_write(monitor_pkg::STATUS_SOFT, 16'($random(seed)));
      bus_write(monitor_pkg::STATUS_HARD, 16'($random(seed)));
      settle();
      compare_model($sformatf("burst %0d clear", b));
    end
    end_test();
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    wb_req     = '0;
    adc_sample = '0;
    errors     = 0;
    checks     = 0;
    model_reset();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_defaults();
    test_register_access();
    test_soft_window();
    test_hard_window();
    test_pipeline_filter();
    test_random_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // bounds the run in case the DUT stops answering.
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== tb.f ====
logic/bus_pkg.sv
logic/monitor_pkg.sv
logic/sample_router.sv
logic/level_channel.sv
logic/violation_collector.sv
logic/wb_monitor_regs.sv
logic/health_monitor_top.sv
verif/tb_health_monitor.sv

// ==== Makefile ====
TOP := tb_health_monitor
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
